//--- verilog/trellisPkg.sv
// sample, register bus, control word and DAC types plus trellis address constants
`default_nettype none

package trellisPkg;

   // --------------------------------------------------
   // sample path
   // --------------------------------------------------
   localparam int SAMPLE_BITS = 18;

   typedef logic signed [SAMPLE_BITS-1:0] sampleT;

   typedef struct packed {
      sampleT i;
      sampleT q;
   } iqSampleT;

   // --------------------------------------------------
   // register bus
   // --------------------------------------------------
   typedef struct packed {
      logic        req;
      logic        wr;
      logic [11:0] addr;
      logic [31:0] wdata;
   } regReqT;

   // control word layout
   typedef struct packed {
      logic [29:0] reserved;
      logic        symbolDelay;
      logic        symbolSlip;
   } ctrlFieldsT;

   // one bus word, read either as raw data or as control fields
   typedef union packed {
      logic [31:0] raw;
      ctrlFieldsT  fields;
   } ctrlWordT;

   // addr[11:8] of the trellis block
   localparam logic [3:0]  TRELLIS_SPACE   = 4'h4;
   localparam logic [11:0] TRELLIS_CONTROL = 12'h400;

   // --------------------------------------------------
   // DAC monitor
   // --------------------------------------------------
   localparam int DAC_CHANNELS = 3;

   typedef logic [3:0] dacSelT;

   localparam dacSelT DAC_TRELLIS_I = 4'd0;
   localparam dacSelT DAC_TRELLIS_Q = 4'd1;

   typedef struct packed {
      logic   sync;
      sampleT data;
   } dacOutT;

endpackage

`default_nettype wire

//--- verilog/symbolSlip.sv
// symbol strobe reclocking and one-shot removal of a single symbol strobe
`default_nettype none

module symbolSlip (
   input  logic clk,
   input  logic reset,
   input  logic symEnIn,
   input  logic sym2xEnIn,
   input  logic slipRequest,
   output logic symEn,
   output logic sym2xEn,
   output logic slipPending
);

   logic slipNow;

   // first symbol strobe seen while a slip is armed
   assign slipNow = symEnIn && slipPending;

   // --------------------------------------------------
   // strobe reclock and slip state
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         symEn       <= 1'b0;
         sym2xEn     <= 1'b0;
         slipPending <= 1'b0;
      end else begin
         sym2xEn <= sym2xEnIn;
         // the armed strobe is swallowed, all others pass one cycle late
         symEn <= symEnIn && !slipPending;

         // a fresh request wins, so a request landing on the
         // swallowed strobe arms the next one
         if (slipRequest) begin
            slipPending <= 1'b1;
         end else if (slipNow) begin
            slipPending <= 1'b0;
         end
      end
   end

   // consuming the slip leaves no symbol strobe behind
   slipDropsOneStrobe : assert property (
      @(posedge clk) disable iff (reset)
      slipNow && !slipRequest |=> !symEn && !slipPending
   );

endmodule

`default_nettype wire

//--- verilog/sampleAlign.sv
// I/Q reclock, double-rate strobe latch and optional one-strobe delay stage
`default_nettype none

module sampleAlign import trellisPkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     sym2xEn,
   input  logic     symbolDelay,
   input  iqSampleT iqIn,
   output iqSampleT aligned
);

   iqSampleT iqReg;
   iqSampleT heldSample;

   // same one-cycle lag as the strobes in symbolSlip
   always_ff @(posedge clk) begin
      iqReg <= iqIn;
   end

   // --------------------------------------------------
   // strobe latch
   // --------------------------------------------------

   // previous strobe's sample, refreshed on every strobe
   always_ff @(posedge clk) begin
      if (sym2xEn) begin
         heldSample <= iqReg;
      end
   end

   // delay set moves the trellis boundary by half a symbol
   always_ff @(posedge clk) begin
      if (reset) begin
         aligned <= '0;
      end else if (sym2xEn) begin
         if (symbolDelay) begin
            aligned <= heldSample;
         end else begin
            aligned <= iqReg;
         end
      end
   end

   // downstream sync timing relies on this
   alignedOnStrobe : assert property (
      @(posedge clk) disable iff (reset)
      !$stable(aligned) |-> $past(sym2xEn)
   );

endmodule

`default_nettype wire

//--- verilog/trellisRegs.sv
// four-phase register bus slave with the trellis control register
`default_nettype none

module trellisRegs import trellisPkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  regReqT      regReq,
   input  logic        slipPending,
   output logic        regAck,
   output logic [31:0] regRdata,
   output logic        symbolDelay,
   output logic        slipRequest
);

   logic     access;
   logic     trellisSpace;
   logic     controlHit;
   ctrlWordT wrWord;
   ctrlWordT rdWord;

   // --------------------------------------------------
   // address decode
   // --------------------------------------------------

   // one access per handshake, on the first req cycle with ack low
   assign access       = regReq.req && !regAck;
   assign trellisSpace = regReq.addr[11:8] == TRELLIS_SPACE;
   assign controlHit   = regReq.addr == TRELLIS_CONTROL;

   assign wrWord.raw = regReq.wdata;

   // readback shows the live slip state
   always_comb begin
      rdWord                    = '0;
      rdWord.fields.symbolDelay = symbolDelay;
      rdWord.fields.symbolSlip  = slipPending;
   end

   // --------------------------------------------------
   // handshake
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         regAck <= 1'b0;
      end else if (access) begin
         regAck <= 1'b1;
      end else if (!regReq.req) begin
         // master has released req
         regAck <= 1'b0;
      end
   end

   // held for the whole ack phase
   always_ff @(posedge clk) begin
      if (access) begin
         if (trellisSpace) begin
            regRdata <= rdWord.raw;
         end else begin
            regRdata <= '0;
         end
      end
   end

   // --------------------------------------------------
   // control register
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         symbolDelay <= 1'b0;
         slipRequest <= 1'b0;
      end else begin
         slipRequest <= 1'b0;
         if (access && regReq.wr && controlHit) begin
            symbolDelay <= wrWord.fields.symbolDelay;
            // slip bit is a command, not stored
            slipRequest <= wrWord.fields.symbolSlip;
         end
      end
   end

   ackFollowsReq : assert property (
      @(posedge clk) disable iff (reset)
      $rose(regAck) |-> $past(regReq.req)
   );

   slipIsSingleCycle : assert property (
      @(posedge clk) disable iff (reset)
      slipRequest |=> !slipRequest
   );

endmodule

`default_nettype wire

//--- verilog/dacMux.sv
// per-channel DAC source selection with registered data and sync pulse
`default_nettype none

module dacMux import trellisPkg::*; #(
   parameter int NUM_CHANNELS = DAC_CHANNELS
) (
   input  logic     clk,
   input  logic     reset,
   input  dacSelT   dacSel [NUM_CHANNELS],
   input  iqSampleT aligned,
   input  logic     sym2xEn,
   output dacOutT   dacOut [NUM_CHANNELS]
);

   logic alignedValid;

   // aligned takes its new sample the cycle after the strobe,
   // so the sync has to follow it
   always_ff @(posedge clk) begin
      if (reset) begin
         alignedValid <= 1'b0;
      end else begin
         alignedValid <= sym2xEn;
      end
   end

   // --------------------------------------------------
   // channel selectors
   // --------------------------------------------------
   for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : gChannel
      dacOutT nextOut;
      dacOutT outReg;

      always_comb begin
         case (dacSel[ch])
            DAC_TRELLIS_I: begin
               nextOut.sync = alignedValid;
               nextOut.data = aligned.i;
            end
            DAC_TRELLIS_Q: begin
               nextOut.sync = alignedValid;
               nextOut.data = aligned.q;
            end
            // unused codes stay silent
            default: begin
               nextOut = '0;
            end
         endcase
      end

      always_ff @(posedge clk) begin
         if (reset) begin
            outReg.sync <= 1'b0;
         end else begin
            outReg.sync <= nextOut.sync;
         end
         outReg.data <= nextOut.data;
      end

      assign dacOut[ch] = outReg;
   end

endmodule

`default_nettype wire

//--- verilog/trellisFrontEnd.sv
// trellis demodulator front end: symbol slip, sample alignment, registers, DAC mux
`default_nettype none

module trellisFrontEnd import trellisPkg::*; #(
   parameter int NUM_CHANNELS = DAC_CHANNELS
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        symEnIn,
   input  logic        sym2xEnIn,
   input  iqSampleT    iqIn,
   input  regReqT      regReq,
   input  dacSelT      dacSel [NUM_CHANNELS],
   output logic        regAck,
   output logic [31:0] regRdata,
   output dacOutT      dacOut [NUM_CHANNELS],
   output logic        symEnOut
);

   logic     sym2xEn;
   logic     slipRequest;
   logic     slipPending;
   logic     symbolDelay;
   iqSampleT aligned;

   // --------------------------------------------------
   // strobes
   // --------------------------------------------------
   symbolSlip slipCtl (
      .clk         (clk),
      .reset       (reset),
      .symEnIn     (symEnIn),
      .sym2xEnIn   (sym2xEnIn),
      .slipRequest (slipRequest),
      .symEn       (symEnOut),
      .sym2xEn     (sym2xEn),
      .slipPending (slipPending)
   );

   // --------------------------------------------------
   // sample path
   // --------------------------------------------------
   sampleAlign align (
      .clk         (clk),
      .reset       (reset),
      .sym2xEn     (sym2xEn),
      .symbolDelay (symbolDelay),
      .iqIn        (iqIn),
      .aligned     (aligned)
   );

   // carrier loop bypassed, aligned samples feed the monitor directly
   dacMux #(
      .NUM_CHANNELS (NUM_CHANNELS)
   ) monitor (
      .clk     (clk),
      .reset   (reset),
      .dacSel  (dacSel),
      .aligned (aligned),
      .sym2xEn (sym2xEn),
      .dacOut  (dacOut)
   );

   // --------------------------------------------------
   // software access
   // --------------------------------------------------
   trellisRegs regs (
      .clk         (clk),
      .reset       (reset),
      .regReq      (regReq),
      .slipPending (slipPending),
      .regAck      (regAck),
      .regRdata    (regRdata),
      .symbolDelay (symbolDelay),
      .slipRequest (slipRequest)
   );

endmodule

`default_nettype wire

//--- verif/trellisFrontEndTb.sv
// testbench with clock, reset, strobe and bus stimulus, reference model and checking assertions
`default_nettype none

module trellisFrontEndTb import trellisPkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int          NUM_CH       = DAC_CHANNELS;
   // the sequence needs about 200 cycles, so this leaves a wide margin
   localparam int          CYCLE_LIMIT  = 2000;
   localparam dacSelT      UNUSED_SEL   = 4'd9;
   localparam logic [11:0] OUTSIDE_ADDR = 12'h300;

   logic        clk;
   logic        reset;
   logic        symEnIn;
   logic        sym2xEnIn;
   iqSampleT    iqIn;
   regReqT      regReq;
   dacSelT      dacSel [NUM_CH];
   logic        regAck;
   logic [31:0] regRdata;
   dacOutT      dacOut [NUM_CH];
   logic        symEnOut;

   // reference model state
   logic        expDelay;
   logic        expPending;
   logic        slipPulse;
   logic        expSymEn;
   logic        expRead;
   logic        pendValid;
   logic        expValid;
   logic        expSync;
   logic [31:0] expRdata;
   iqSampleT    pendCur;
   iqSampleT    pendPrev;
   iqSampleT    lastSample;
   iqSampleT    expAligned;
   iqSampleT    expOut;
   int          strobeCount;
   int          symCount;
   int          dropCount;
   int          slipReads;
   int          syncCount;
   int          busCycles;
   int          cycleCount = 0;

   trellisFrontEnd #(
      .NUM_CHANNELS (NUM_CH)
   ) DUT (
      .clk       (clk),
      .reset     (reset),
      .symEnIn   (symEnIn),
      .sym2xEnIn (sym2xEnIn),
      .iqIn      (iqIn),
      .regReq    (regReq),
      .dacSel    (dacSel),
      .regAck    (regAck),
      .regRdata  (regRdata),
      .dacOut    (dacOut),
      .symEnOut  (symEnOut)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // --------------------------------------------------
   // error reporting
   // --------------------------------------------------
   task automatic reportValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      $display("Fail %s expected %h actual %h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic reportFailure(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1);
   endtask

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount == CYCLE_LIMIT) begin
         reportFailure("run did not finish within the cycle limit");
      end
   end

   // --------------------------------------------------
   // strobe and sample stimulus
   // --------------------------------------------------
   // sym2x every 4 cycles, symbol strobe on every other sym2x
   initial begin
      logic [31:0] rnd;
      logic [1:0]  phase;
      logic        symbolTurn;
      rnd        = $urandom(32'hff1f);
      phase      = 2'd0;
      symbolTurn = 1'b1;
      sym2xEnIn  = 1'b0;
      symEnIn    = 1'b0;
      iqIn       = '0;
      forever begin
         @(negedge clk);
         sym2xEnIn = phase == 2'd0;
         symEnIn   = phase == 2'd0 && symbolTurn;
         if (phase == 2'd0) begin
            symbolTurn = !symbolTurn;
         end
         phase  = phase + 2'd1;
         rnd    = $urandom;
         iqIn.i = rnd[17:0];
         rnd    = $urandom;
         iqIn.q = rnd[17:0];
      end
   end

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------
   always @(posedge clk) begin
      if (reset) begin
         expDelay    <= 1'b0;
         expPending  <= 1'b0;
         slipPulse   <= 1'b0;
         expSymEn    <= 1'b0;
         expRead     <= 1'b0;
         pendValid   <= 1'b0;
         expValid    <= 1'b0;
         expSync     <= 1'b0;
         lastSample  <= '0;
         expAligned  <= '0;
         strobeCount <= 0;
         symCount    <= 0;
      end else begin
         // bus access on the first req cycle with ack low
         slipPulse <= 1'b0;
         if (regReq.req && !regAck) begin
            expRead <= !regReq.wr;
            if (regReq.wr && regReq.addr == TRELLIS_CONTROL) begin
               expDelay  <= regReq.wdata[1];
               slipPulse <= regReq.wdata[0];
            end
            if (regReq.addr[11:8] == TRELLIS_SPACE) begin
               expRdata <= {30'd0, expDelay, expPending};
               if (!regReq.wr && expPending) begin
                  slipReads <= slipReads + 1;
               end
            end else begin
               expRdata <= '0;
            end
         end
         if (regAck && !regReq.req) begin
            busCycles <= busCycles + 1;
         end

         // one armed symbol strobe is dropped
         expSymEn <= symEnIn && !expPending;
         if (slipPulse) begin
            expPending <= 1'b1;
         end else if (symEnIn && expPending) begin
            expPending <= 1'b0;
            dropCount  <= dropCount + 1;
         end
         if (symEnIn) begin
            symCount <= symCount + 1;
         end

         // sample path, three cycles from strobe to DAC
         pendValid <= sym2xEnIn;
         if (sym2xEnIn) begin
            pendCur     <= iqIn;
            pendPrev    <= lastSample;
            lastSample  <= iqIn;
            strobeCount <= strobeCount + 1;
         end
         if (pendValid) begin
            expAligned <= expDelay ? pendPrev : pendCur;
         end
         expValid <= pendValid;
         expSync  <= expValid;
         expOut   <= expAligned;
         if (expSync) begin
            syncCount <= syncCount + 1;
         end
      end
   end

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   idleAfterReset : assert property (@(posedge clk) $fell(reset) |->
      !regAck && !symEnOut && !dacOut[0].sync && !dacOut[1].sync && !dacOut[2].sync)
      else reportFailure("outputs not idle after reset");

   ackRisesOnReq : assert property (@(posedge clk) disable iff (reset)
      regReq.req && !regAck |=> regAck)
      else reportFailure("ack did not rise one cycle after req");

   ackDropsAfterReq : assert property (@(posedge clk) disable iff (reset)
      regAck && !regReq.req |=> !regAck)
      else reportFailure("ack did not drop one cycle after req fell");

   readData : assert property (@(posedge clk) disable iff (reset)
      regAck && expRead |-> regRdata == expRdata)
      else reportValue("regRdata", $sampled(expRdata), $sampled(regRdata));

   symbolStrobe : assert property (@(posedge clk) disable iff (reset)
      symEnOut == expSymEn)
      else reportValue("symEnOut", 32'($sampled(expSymEn)), 32'($sampled(symEnOut)));

   syncI : assert property (@(posedge clk) disable iff (reset)
      dacOut[0].sync == expSync)
      else reportValue("dacOut[0].sync", 32'($sampled(expSync)),
                       32'($sampled(dacOut[0].sync)));

   syncQ : assert property (@(posedge clk) disable iff (reset)
      dacOut[1].sync == expSync)
      else reportValue("dacOut[1].sync", 32'($sampled(expSync)),
                       32'($sampled(dacOut[1].sync)));

   dataI : assert property (@(posedge clk) disable iff (reset)
      expSync |-> dacOut[0].data == expOut.i)
      else reportValue("dacOut[0].data", 32'($sampled(expOut.i)),
                       32'($sampled(dacOut[0].data)));

   dataQ : assert property (@(posedge clk) disable iff (reset)
      expSync |-> dacOut[1].data == expOut.q)
      else reportValue("dacOut[1].data", 32'($sampled(expOut.q)),
                       32'($sampled(dacOut[1].data)));

   // unused select code stays silent
   silentSync : assert property (@(posedge clk) disable iff (reset) !dacOut[2].sync)
      else reportValue("dacOut[2].sync", 32'h0, 32'($sampled(dacOut[2].sync)));

   silentData : assert property (@(posedge clk) disable iff (reset) dacOut[2].data == '0)
      else reportValue("dacOut[2].data", 32'h0, 32'($sampled(dacOut[2].data)));

   // --------------------------------------------------
   // sequence
   // --------------------------------------------------
   // four-phase master, called on a falling edge
   task automatic busAccess(input logic wr, input logic [11:0] addr, input logic [31:0] wdata);
      regReq.req   = 1'b1;
      regReq.wr    = wr;
      regReq.addr  = addr;
      regReq.wdata = wdata;
      do @(negedge clk); while (!regAck);
      regReq.req = 1'b0;
      do @(negedge clk); while (regAck);
   endtask

   task automatic waitStrobes(input int count);
      int target;
      target = strobeCount + count;
      while (strobeCount < target) @(negedge clk);
   endtask

   task automatic waitSymbols(input int count);
      int target;
      target = symCount + count;
      while (symCount < target) @(negedge clk);
   endtask

   initial begin
      reset     = 1'b1;
      regReq    = '0;
      dacSel[0] = DAC_TRELLIS_I;
      dacSel[1] = DAC_TRELLIS_Q;
      dacSel[2] = UNUSED_SEL;
      repeat (3) @(negedge clk);
      reset = 1'b0;

      waitStrobes(12);
      busAccess(1'b0, TRELLIS_CONTROL, 32'h0);
      busAccess(1'b1, TRELLIS_CONTROL, 32'h2);
      busAccess(1'b0, TRELLIS_CONTROL, 32'h0);
      // outside read while the control word is nonzero
      busAccess(1'b0, OUTSIDE_ADDR, 32'h0);
      waitStrobes(8);

      // start the slip right after a symbol strobe so the readback sees it armed
      waitSymbols(1);
      busAccess(1'b1, TRELLIS_CONTROL, 32'h3);
      busAccess(1'b0, TRELLIS_CONTROL, 32'h0);
      waitSymbols(3);
      busAccess(1'b0, TRELLIS_CONTROL, 32'h0);
      busAccess(1'b1, TRELLIS_CONTROL, 32'h0);
      waitStrobes(10);

      if (syncCount < 30 || dropCount != 1 || slipReads < 1 || busCycles != 8) begin
         $display("test sequence did not reach every check");
         $display("Simulation failed");
         $fatal(1);
      end else begin
         $display("Simulation completed successfully");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- all.f
verilog/trellisPkg.sv
verilog/symbolSlip.sv
verilog/sampleAlign.sv
verilog/trellisRegs.sv
verilog/dacMux.sv
verilog/trellisFrontEnd.sv
verif/trellisFrontEndTb.sv

//--- runSim.sh
#!/bin/bash
# compile the trellis front end testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module trellisFrontEndTb -f all.f -o simv \
   || { echo "build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && { echo "run FAILED"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "no result in log"; exit 1; }
echo "run passed"
